// File: verilog/mem_link_pkg.sv
//////////////////////////////
// Serial memory link shared definitions
//////////////////////////////

package mem_link_pkg;

	// Serial line timing.
	localparam int CLKS_PER_BIT = 4;

	// Frame limits.
	localparam int MSG_BYTES_MAX = 9;
	localparam int MSG_BITS = 72;
	localparam int LEN_BITS = 5;

	// Payload lengths of each message kind.
	localparam int READ_LEN = 5;
	localparam int WRITE_LEN = 9;
	localparam int REPLY_LEN = 4;

	// Byte memory.
	localparam int MEM_BYTES = 2048;
	localparam int MEM_ADDR_BITS = 11;

	typedef enum logic [1:0] {
		LINE_IDLE,
		LINE_START,
		LINE_DATA,
		LINE_STOP
	} line_state_t;

	typedef enum logic [1:0] {
		LINK_HEADER,
		LINK_PAYLOAD,
		LINK_REPLY
	} link_state_t;

	typedef enum logic [1:0] {
		REQ_READ,
		REQ_WRITE,
		REQ_INVALID
	} req_kind_t;

endpackage

// File: verilog/uart_tx.sv
//////////////////////////////
// UART transmitter
//////////////////////////////
`timescale 1ns/1ps

module uart_tx import mem_link_pkg::*; (
	input  logic       CLK,
	input  logic       RST,
	input  logic [7:0] tx_data,
	input  logic       tx_start,
	output logic       tx_ready,
	output logic       tx
);

	line_state_t state;
	logic [$clog2(CLKS_PER_BIT)-1:0] cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift;
	logic bit_end;

	assign bit_end = (cnt == CLKS_PER_BIT - 1);

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state <= LINE_IDLE;
			tx <= 1'b1;
			tx_ready <= 1'b1;
			cnt <= '0;
			bit_idx <= '0;
		end else begin
			cnt <= bit_end ? '0 : cnt + 1'b1;
			case (state)
				LINE_IDLE: begin
					cnt <= '0;
					if (tx_start) begin
						tx <= 1'b0; // Start bit.
						tx_ready <= 1'b0;
						state <= LINE_START;
					end
				end
				LINE_START: if (bit_end) begin
					tx <= shift[0];
					bit_idx <= '0;
					state <= LINE_DATA;
				end
				LINE_DATA: if (bit_end) begin
					if (bit_idx == 3'd7) begin
						tx <= 1'b1; // Stop bit.
						state <= LINE_STOP;
					end else begin
						tx <= shift[0];
						bit_idx <= bit_idx + 1'b1;
					end
				end
				default: if (bit_end) begin
					tx_ready <= 1'b1;
					state <= LINE_IDLE;
				end
			endcase
		end
	end

	// Data bits leave LSB first.
	always_ff @(posedge CLK) begin
		if (state == LINE_IDLE && tx_start)
			shift <= tx_data;
		else if ((state == LINE_START || state == LINE_DATA) && bit_end)
			shift <= shift >> 1;
	end

	a_idle_high: assert property (@(posedge CLK) disable iff (RST)
		(state == LINE_IDLE) |-> tx);

endmodule

// File: verilog/uart_rx.sv
//////////////////////////////
// UART receiver
//////////////////////////////
`timescale 1ns/1ps

module uart_rx import mem_link_pkg::*; (
	input  logic       CLK,
	input  logic       RST,
	input  logic       rx,
	output logic [7:0] rx_data,
	output logic       rx_valid
);

	line_state_t state;
	logic rx_meta, rx_sync;
	logic [$clog2(CLKS_PER_BIT)-1:0] cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift;
	logic bit_end;

	assign bit_end = (cnt == CLKS_PER_BIT - 1);

	//////////////////////////////
	// Input synchronizer
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	//////////////////////////////
	// Bit engine
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state <= LINE_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			cnt <= bit_end ? '0 : cnt + 1'b1;
			case (state)
				LINE_IDLE: begin
					cnt <= '0;
					if (!rx_sync)
						state <= LINE_START;
				end
				LINE_START: if (cnt == CLKS_PER_BIT / 2 - 1) begin
					// Recheck the start bit at its middle.
					cnt <= '0;
					bit_idx <= '0;
					state <= rx_sync ? LINE_IDLE : LINE_DATA;
				end
				LINE_DATA: if (bit_end) begin
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= LINE_STOP;
				end
				default: if (bit_end) begin
					rx_valid <= rx_sync; // Framing error drops the byte.
					state <= LINE_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == LINE_DATA && bit_end)
			shift <= {rx_sync, shift[7:1]};
		if (state == LINE_STOP && bit_end)
			rx_data <= shift;
	end

endmodule

// File: verilog/frame_link.sv
//////////////////////////////
// Message framing link
//////////////////////////////
`timescale 1ns/1ps

module frame_link import mem_link_pkg::*; (
	input  logic                CLK,
	input  logic                RST,
	input  logic [7:0]          rx_data,
	input  logic                rx_valid,
	output logic [MSG_BITS-1:0] msg_data,
	output logic [LEN_BITS-1:0] msg_length,
	output logic                msg_valid,
	input  logic [31:0]         reply_data,
	input  logic                reply_valid,
	output logic                reply_ready,
	output logic [7:0]          tx_data,
	output logic                tx_start,
	input  logic                tx_ready
);

	link_state_t rx_state, tx_state;
	logic [LEN_BITS-1:0] hdr_len, rx_idx;
	logic hdr_ok;
	logic [39:0] reply_word, tx_shift;
	logic [2:0] tx_left;
	logic send_first, send_next;

	//////////////////////////////
	// Receive side
	assign hdr_len = rx_data[LEN_BITS-1:0];
	assign hdr_ok = (rx_data[7:LEN_BITS] == '0) && (hdr_len != '0)
		&& (hdr_len <= MSG_BYTES_MAX);

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			rx_state <= LINK_HEADER;
			rx_idx <= '0;
			msg_length <= '0;
			msg_valid <= 1'b0;
		end else begin
			msg_valid <= 1'b0;
			if (rx_valid) begin
				case (rx_state)
					LINK_HEADER: if (hdr_ok) begin
						msg_length <= hdr_len;
						rx_idx <= '0;
						rx_state <= LINK_PAYLOAD;
					end
					LINK_PAYLOAD: begin
						rx_idx <= rx_idx + 1'b1;
						if (rx_idx == msg_length - 1'b1) begin
							msg_valid <= 1'b1;
							rx_state <= LINK_HEADER;
						end
					end
					default: rx_state <= LINK_HEADER;
				endcase
			end
		end
	end

	// Payload fills the bus from byte 0 upward.
	always_ff @(posedge CLK) begin
		if (rx_valid && rx_state == LINK_HEADER && hdr_ok)
			msg_data <= '0;
		else if (rx_valid && rx_state == LINK_PAYLOAD)
			msg_data[rx_idx*8 +: 8] <= rx_data;
	end

	//////////////////////////////
	// Transmit side
	// LINK_HEADER here means no reply in progress.
	assign reply_ready = (tx_state == LINK_HEADER);
	assign reply_word = {reply_data, 8'(REPLY_LEN)};
	assign send_first = reply_valid && tx_ready && !tx_start;
	assign send_next = !reply_valid && tx_state == LINK_REPLY && tx_ready && !tx_start;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			tx_state <= LINK_HEADER;
			tx_start <= 1'b0;
			tx_left <= '0;
		end else begin
			tx_start <= send_first || send_next;
			if (reply_valid) begin
				tx_state <= LINK_REPLY;
				tx_left <= send_first ? 3'(REPLY_LEN) : 3'(REPLY_LEN + 1);
			end else if (send_next) begin
				tx_left <= tx_left - 1'b1;
				if (tx_left == 3'd1)
					tx_state <= LINK_HEADER; // Last byte handed off.
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (reply_valid)
			tx_shift <= send_first ? reply_word >> 8 : reply_word;
		else if (send_next)
			tx_shift <= tx_shift >> 8;
		if (send_first)
			tx_data <= reply_word[7:0];
		else if (send_next)
			tx_data <= tx_shift[7:0];
	end

	a_msg_len: assert property (@(posedge CLK) disable iff (RST)
		msg_valid |-> (msg_length >= 1 && msg_length <= MSG_BYTES_MAX));

endmodule

// File: verilog/mem_server.sv
//////////////////////////////
// Byte memory server
//////////////////////////////
`timescale 1ns/1ps

module mem_server import mem_link_pkg::*; (
	input  logic                CLK,
	input  logic                RST,
	input  logic [MSG_BITS-1:0] msg_data,
	input  logic [LEN_BITS-1:0] msg_length,
	input  logic                msg_valid,
	output logic [31:0]         reply_data,
	output logic                reply_valid,
	input  logic                reply_ready
);

	// Memory powers up cleared.
	logic [7:0] mem [MEM_BYTES] = '{default: 8'h00};

	req_kind_t kind;
	logic [MEM_ADDR_BITS-1:0] rd_addr, wr_addr;
	logic [3:0] wr_mask;
	logic [31:0] wr_word, rd_word, pend_data;
	logic pending, accept, send_pend, send_read, hold_read;

	//////////////////////////////
	// Request decode
	assign rd_addr = msg_data[MEM_ADDR_BITS-1:0];
	assign wr_word = msg_data[31:0];
	assign wr_addr = msg_data[32 +: MEM_ADDR_BITS];
	assign wr_mask = msg_data[64 +: 4];

	always_comb begin
		if (msg_length == LEN_BITS'(READ_LEN) && !msg_data[32])
			kind = REQ_READ;
		else if (msg_length == LEN_BITS'(WRITE_LEN))
			kind = REQ_WRITE;
		else
			kind = REQ_INVALID;
	end

	always_comb begin
		for (int k = 0; k < 4; k++)
			rd_word[8*k +: 8] = mem[MEM_ADDR_BITS'(rd_addr + k)]; // Wraps at the top.
	end

	always_ff @(posedge CLK) begin
		if (accept && kind == REQ_WRITE) begin
			for (int k = 0; k < 4; k++)
				if (wr_mask[k])
					mem[MEM_ADDR_BITS'(wr_addr + k)] <= wr_word[8*k +: 8];
		end
	end

	//////////////////////////////
	// Reply path
	assign accept = msg_valid && !pending; // A pending reply blocks new requests.
	assign send_pend = pending && reply_ready && !reply_valid;
	assign send_read = accept && kind == REQ_READ && reply_ready && !reply_valid;
	assign hold_read = accept && kind == REQ_READ && !send_read;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			reply_valid <= 1'b0;
			pending <= 1'b0;
		end else begin
			reply_valid <= send_pend || send_read;
			if (send_pend)
				pending <= 1'b0;
			else if (hold_read)
				pending <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (send_pend)
			reply_data <= pend_data;
		else if (send_read)
			reply_data <= rd_word;
		if (hold_read)
			pend_data <= rd_word;
	end

	a_reply_ready: assert property (@(posedge CLK) disable iff (RST)
		reply_valid |-> reply_ready);

endmodule

// File: verilog/uart_mem_top.sv
//////////////////////////////
// UART memory top level
//////////////////////////////
`timescale 1ns/1ps

module uart_mem_top import mem_link_pkg::*; (
	input  logic CLK,
	input  logic RST,
	input  logic rx,
	output logic tx
);

	logic [7:0] rx_data, tx_data;
	logic rx_valid, tx_start, tx_ready;
	logic [MSG_BITS-1:0] msg_data;
	logic [LEN_BITS-1:0] msg_length;
	logic msg_valid;
	logic [31:0] reply_data;
	logic reply_valid, reply_ready;

	uart_rx u_rx (.CLK, .RST, .rx, .rx_data, .rx_valid);

	frame_link u_link (
		.CLK, .RST,
		.rx_data, .rx_valid,
		.msg_data, .msg_length, .msg_valid,
		.reply_data, .reply_valid, .reply_ready,
		.tx_data, .tx_start, .tx_ready
	);

	mem_server u_mem (
		.CLK, .RST,
		.msg_data, .msg_length, .msg_valid,
		.reply_data, .reply_valid, .reply_ready
	);

	uart_tx u_tx (.CLK, .RST, .tx_data, .tx_start, .tx_ready, .tx);

endmodule

// File: testbench/tb_uart_mem.sv
//////////////////////////////
// UART memory testbench
//////////////////////////////
`timescale 1ns/1ps

module tb_uart_mem import mem_link_pkg::*; ();

	localparam int FRAME_CLKS = 10 * 10 * CLKS_PER_BIT; // One 10-byte frame.
	localparam int NUM_FRAMES = 66; // Frames sent over all six tests.
	localparam int WATCHDOG_CLKS = NUM_FRAMES * FRAME_CLKS * 2;

	logic CLK, RST, rx, tx;
	logic [7:0] model_mem [MEM_BYTES];
	logic [39:0] reply_q [$]; // Reply word above the header byte.
	logic [31:0] exp_q [$];
	int reads_sent = 0;
	int replies_seen = 0;
	int errors = 0;
	int test_errs = 0;
	int test_num = 0;
	int tests_ok = 0;
	int tests_bad = 0;
	integer seed;

	uart_mem_top u_dut (.CLK, .RST, .rx, .tx);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	//////////////////////////////
	// Host side
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			#1 rx = bits[i];
			repeat (CLKS_PER_BIT) @(posedge CLK);
		end
	endtask

	task automatic send_frame(input logic [7:0] hdr, input logic [71:0] payload, input int len);
		send_byte(hdr);
		for (int i = 0; i < len; i++)
			send_byte(payload[8*i +: 8]);
	endtask

	function automatic logic [31:0] model_word(input logic [31:0] addr);
		logic [31:0] w;
		for (int k = 0; k < 4; k++)
			w[8*k +: 8] = model_mem[(addr + k) % MEM_BYTES];
		return w;
	endfunction

	task automatic host_read(input logic [31:0] addr);
		exp_q.push_back(model_word(addr));
		reads_sent++;
		send_frame(8'(READ_LEN), {40'h0, addr}, READ_LEN);
	endtask

	task automatic host_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] mask);
		for (int k = 0; k < 4; k++)
			if (mask[k])
				model_mem[(addr + k) % MEM_BYTES] = data[8*k +: 8];
		send_frame(8'(WRITE_LEN), {4'h0, mask, addr, data}, WRITE_LEN);
	endtask

	// Matches every queued reply against the model, then watches for extras.
	task automatic check_replies();
		int waited;
		logic [39:0] got;
		logic [31:0] exp;
		waited = 0;
		while (reply_q.size() < exp_q.size() && waited < 2 * FRAME_CLKS) begin
			@(posedge CLK);
			waited++;
		end
		assert (reply_q.size() >= exp_q.size()) else begin
			$display("missing reply: %0d expected, %0d received", exp_q.size(), reply_q.size());
			errors++;
		end
		while (reply_q.size() > 0 && exp_q.size() > 0) begin
			got = reply_q.pop_front();
			exp = exp_q.pop_front();
			assert (got[7:0] == 8'(REPLY_LEN)) else begin
				$display("ERROR reply_header expected %h got %h", 8'(REPLY_LEN), got[7:0]);
				errors++;
			end
			assert (got[39:8] == exp) else begin
				$display("ERROR reply_data expected %h got %h", exp, got[39:8]);
				errors++;
			end
		end
		exp_q.delete();
		repeat (FRAME_CLKS) @(posedge CLK);
		assert (reply_q.size() == 0) else begin
			$display("extra reply: %0d frames arrived without a request", reply_q.size());
			errors++;
		end
		reply_q.delete();
	endtask

	task automatic finish_test(input string name);
		test_num++;
		if (errors == test_errs) begin
			tests_ok++;
			$display("test %0d %s: ok", test_num, name);
		end else begin
			tests_bad++;
			$display("test %0d %s: %0d errors", test_num, name, errors - test_errs);
		end
		test_errs = errors;
	endtask

	//////////////////////////////
	// Reply decoder on tx
	initial begin : tx_decoder
		logic [39:0] frame;
		logic [7:0] b;
		int n;
		n = 0;
		frame = '0;
		forever begin
			do @(negedge CLK); while (tx !== 1'b0 || RST);
			repeat (CLKS_PER_BIT / 2) @(negedge CLK); // Middle of the start bit.
			if (tx === 1'b0) begin
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge CLK);
					b[i] = tx;
				end
				repeat (CLKS_PER_BIT) @(negedge CLK);
				assert (tx === 1'b1) else begin
					$display("tx stop bit was sampled low");
					errors++;
				end
				frame[8*n +: 8] = b;
				n++;
				if (n == REPLY_LEN + 1) begin
					reply_q.push_back(frame);
					replies_seen++;
					n = 0;
				end
			end
		end
	end

	a_tx_reset: assert property (@(posedge CLK) RST |-> tx) else begin
		$display("ERROR tx expected 1 got %h during reset", tx);
		errors++;
	end

	// A reply may only start while a read is still unanswered.
	a_tx_unrequested: assert property (@(posedge CLK) disable iff (RST)
		$fell(tx) |-> replies_seen < reads_sent) else begin
		$display("tx started a reply with no read outstanding");
		errors++;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CLKS) @(posedge CLK);
		$display("timeout: run did not finish within %0d clocks", WATCHDOG_CLKS);
		$display("sim failed");
		$finish;
	end

	//////////////////////////////
	// Tests
	initial begin
		logic [31:0] addr;
		seed = 32'he320;
		for (int a = 0; a < MEM_BYTES; a++)
			model_mem[a] = 8'h00;
		rx = 1'b1;
		RST = 1'b1;
		repeat (16) @(posedge CLK);
		#1 RST = 1'b0;

		repeat (100) begin
			@(negedge CLK);
			assert (tx === 1'b1) else begin
				$display("ERROR tx expected 1 got %h after reset", tx);
				errors++;
			end
		end
		@(posedge CLK);
		host_read(32'h0000_0000);
		host_read(32'h0000_07ff);
		host_read($random(seed));
		check_replies();
		finish_test("reset reads zero");

		host_write(32'h0000_0123, 32'hdead_beef, 4'hf);
		host_read(32'h0000_0123);
		host_write(32'h0000_0400, 32'h1234_5678, 4'hf);
		host_read(32'h0000_0400);
		check_replies();
		finish_test("full write then read");

		host_write(32'h0000_0200, 32'h1111_1111, 4'hf);
		host_write(32'h0000_0200, 32'haabb_ccdd, 4'b0101);
		host_read(32'h0000_0200);
		host_write(32'h0000_0200, 32'h5566_7788, 4'b1000);
		host_read(32'h0000_0200);
		host_write(32'h0000_0201, 32'h9999_9999, 4'b0110); // Offset start address.
		host_read(32'h0000_0200);
		check_replies();
		finish_test("partial masks");

		host_write(32'h0000_07ff, 32'ha1b2_c3d4, 4'hf);
		host_read(32'h0000_0000);
		host_read(32'h0000_07ff);
		host_write(32'h0000_1805, 32'h0f0e_0d0c, 4'hf);
		host_read(32'h0000_0005);
		host_read(32'hffff_f805);
		check_replies();
		finish_test("address wrap");

		host_write(32'h0000_0300, 32'hcafe_f00d, 4'hf);
		send_frame(8'h03, {48'h0, 24'h00_0300}, 3);
		send_frame(8'h07, {16'h0, 24'h00_0300, 32'h1234_5678}, 7);
		send_frame(8'h05, {32'h0, 8'h01, 32'h0000_0300}, 5);
		send_frame(8'h29, {8'h0f, 32'h0000_0300, 32'h5555_5555}, 9); // Upper header bit set.
		check_replies();
		host_read(32'h0000_0300);
		check_replies();
		finish_test("invalid frames");

		// Low address bits stay under 64 so reads often hit earlier writes.
		for (int i = 0; i < 40; i++) begin
			addr = $random(seed) & 32'hffff_f83f;
			if ($random(seed) & 1)
				host_read(addr);
			else
				host_write(addr, $random(seed), 4'($random(seed)));
		end
		check_replies();
		finish_test("random traffic");

		$display("tests passed: %0d, tests failed: %0d", tests_ok, tests_bad);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: uart_mem_top.f
verilog/mem_link_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/frame_link.sv
verilog/mem_server.sv
verilog/uart_mem_top.sv
testbench/tb_uart_mem.sv
